// ==== vlog.f ====
logic/sens_pkg.sv
logic/cmd_deframer.sv
logic/sens_sync.sv
logic/chan_status.sv
logic/status_router4.sv
logic/sensors_top.sv
test/sensors_tb.sv

// ==== Bender.yml ====
package:
  name: sensors

sources:
  - logic/sens_pkg.sv
  - logic/cmd_deframer.sv
  - logic/sens_sync.sv
  - logic/chan_status.sv
  - logic/status_router4.sv
  - logic/sensors_top.sv
  - target: test
    files:
      - test/sensors_tb.sv

// ==== test/sensors_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sensors_tb;

    import sens_pkg::*;

    localparam int max_frames  = 24;                    // frames sent over all tests
    localparam int max_frame_c = 2 * 18 + 6;            // longest frame in cycles
    localparam int watchdog_ns = (max_frames * max_frame_c + 20 * 9 + 600) * 10;

    logic        mclk = 1'b0;
    logic        rst;
    logic [7:0]  cmd_ad_in;
    logic        cmd_stb_in;
    logic [3:0]  sof_in, eof_in, line_in;
    logic [3:0]  sof_out_mclk, eof_out_mclk, sof_late_mclk;
    logic [7:0]  status_ad;
    logic        status_rq;
    logic        status_start;

    // reference model state
    logic        wr_go;                                  // register write lands this cycle
    logic [15:0] wr_addr_m;
    logic [31:0] wr_data_m;
    logic [15:0] mult_m [4], late_m [4], npos [4], fpos [4], lcnt [4], fcnt [4];
    logic [1:0]  mode_m [4];
    logic [5:0]  seq_m [4];
    logic [31:0] snap [4];                               // packet bytes, byte 0 lowest
    logic [3:0]  open_m, ldone, lflag, pend;
    logic [3:0]  exp_sof, exp_eof, exp_late;
    logic [1:0]  r_state, r_sel, r_cnt;                  // 0 idle, 1 offer, 2 send
    logic        exp_rq;
    logic [7:0]  exp_ad;
    int          pkt_cnt;
    int          max_delay, hold_cnt;
    int          c, l, m, seed_rd;
    logic [5:0]  seq;

    sensors_top dut (
        .mclk, .rst, .cmd_ad_in, .cmd_stb_in, .sof_in, .eof_in, .line_in,
        .sof_out_mclk, .eof_out_mclk, .sof_late_mclk, .status_ad, .status_rq, .status_start
    );

    always #5 mclk = ~mclk;

    function automatic logic [15:0] chn_addr(input int ch, input int rel);
        return 16'(sensor_group_addr + ch * sensor_base_inc + rel);
    endfunction

    function automatic logic [1:0] rr_pick(input logic [3:0] p, input logic [1:0] last);
        logic [1:0] pick;
        logic [1:0] idx;
        logic       found;
        pick  = last;
        found = 1'b0;
        for (int k = 1; k <= 4; k++) begin
            idx = last + 2'(k);                          // wraps mod 4
            if (p[idx] && !found) begin
                pick  = idx;
                found = 1'b1;
            end
        end
        return pick;
    endfunction

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_on_failure($sformatf("** Error: %s is 0x%0h, expected 0x%0h at %0t",
                                  name, got, exp, $time));
    endtask

    always @(posedge mclk) begin
        logic        acc, cls, lhit, ev, wr_ctrl, ln_nx;
        logic [15:0] cnt_nx;
        logic [5:0]  sq_nx;
        logic [3:0]  pend_nx;
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                mult_m[i] <= '0;
                late_m[i] <= 16'(sens_sync_late_dflt);
                npos[i]   <= '0;
                fpos[i]   <= '0;
                lcnt[i]   <= '0;
                fcnt[i]   <= '0;
                mode_m[i] <= st_off;
                seq_m[i]  <= '0;
            end
            {open_m, lflag, pend, exp_sof, exp_eof, exp_late} <= '0;
            ldone   <= '1;
            r_state <= 2'd0;
            r_sel   <= 2'd3;                             // channel 0 served first
            r_cnt   <= 2'd0;
            pkt_cnt <= 0;
        end else begin
            pend_nx = pend;
            for (int i = 0; i < 4; i++) begin
                acc  = sof_in[i] && npos[i] == '0;       // first frame of a group
                cls  = eof_in[i] && open_m[i] && fpos[i] == mult_m[i];
                lhit = line_in[i] && open_m[i] && !ldone[i] && (lcnt[i] + 16'd1 == late_m[i]);
                exp_sof[i]  <= acc;
                exp_eof[i]  <= cls;
                exp_late[i] <= (acc && late_m[i] == '0) || lhit || (cls && !ldone[i]);
                if (acc) begin
                    open_m[i] <= 1'b1;
                    lcnt[i]   <= '0;
                    ldone[i]  <= (late_m[i] == '0);
                end else begin
                    if (line_in[i] && open_m[i] && !ldone[i]) lcnt[i] <= lcnt[i] + 16'd1;
                    if (lhit) ldone[i] <= 1'b1;
                    if (cls) begin
                        open_m[i] <= 1'b0;
                        ldone[i]  <= 1'b1;               // group closed before late line
                    end
                end
                if (wr_go && wr_addr_m == chn_addr(i, sens_sync_mult)) begin
                    mult_m[i] <= wr_data_m[15:0];
                    npos[i]   <= '0;
                end else if (sof_in[i]) begin
                    fpos[i] <= npos[i];
                    npos[i] <= (npos[i] == mult_m[i]) ? 16'd0 : npos[i] + 16'd1;
                end
                if (wr_go && wr_addr_m == chn_addr(i, sens_sync_late)) late_m[i] <= wr_data_m[15:0];
                // status source
                wr_ctrl = wr_go && wr_addr_m == chn_addr(i, sens_status_ctrl);
                sq_nx   = wr_ctrl ? wr_data_m[7:2] : seq_m[i];
                ln_nx   = exp_late[i] || (lflag[i] && !exp_sof[i]);
                cnt_nx  = fcnt[i] + 16'(exp_sof[i]);
                fcnt[i]  <= cnt_nx;
                lflag[i] <= ln_nx;
                if (wr_ctrl) begin
                    seq_m[i]  <= sq_nx;
                    mode_m[i] <= (wr_data_m[1:0] == st_auto) ? st_auto : st_off;
                end
                ev = (wr_ctrl && wr_data_m[1:0] == st_once) || (exp_late[i] && mode_m[i] == st_auto);
                if (ev && !pend[i] && !(r_state == 2'd2 && r_sel == 2'(i))) begin
                    pend_nx[i] = 1'b1;
                    snap[i] <= {cnt_nx, sq_nx, ln_nx, open_m[i],
                                8'(status_reg_base + i * status_reg_inc)};
                end
            end
            case (r_state)
                2'd0: begin
                    if (pend != '0) begin
                        r_sel   <= rr_pick(pend, r_sel);
                        r_state <= 2'd1;
                    end
                end
                2'd1: begin
                    if (status_start) begin
                        pend_nx[r_sel] = 1'b0;
                        pkt_cnt <= pkt_cnt + 1;
                        r_cnt   <= 2'd1;
                        r_state <= 2'd2;
                    end
                end
                default: begin
                    if (r_cnt == 2'd3) r_state <= 2'd0; // last byte out
                    r_cnt <= r_cnt + 2'd1;
                end
            endcase
            pend <= pend_nx;
        end
    end

    assign exp_rq = (r_state == 2'd1);
    assign exp_ad = snap[r_sel][8 * ((r_state == 2'd2) ? r_cnt : 2'd0) +: 8];

    a_sof: assert property (@(posedge mclk) disable iff (rst) sof_out_mclk == exp_sof)
        else report_mismatch("sof_out_mclk", $sampled(sof_out_mclk), $sampled(exp_sof));
    a_eof: assert property (@(posedge mclk) disable iff (rst) eof_out_mclk == exp_eof)
        else report_mismatch("eof_out_mclk", $sampled(eof_out_mclk), $sampled(exp_eof));
    a_late: assert property (@(posedge mclk) disable iff (rst) sof_late_mclk == exp_late)
        else report_mismatch("sof_late_mclk", $sampled(sof_late_mclk), $sampled(exp_late));
    a_rq: assert property (@(posedge mclk) disable iff (rst) status_rq == exp_rq)
        else report_mismatch("status_rq", $sampled(status_rq), $sampled(exp_rq));
    a_ad: assert property (@(posedge mclk) disable iff (rst)
                           (exp_rq || r_state == 2'd2) |-> status_ad == exp_ad)
        else report_mismatch("status_ad", $sampled(status_ad), $sampled(exp_ad));

    // downstream takes byte 0 after a random wait
    always @(negedge mclk) begin
        if (status_start) begin
            status_start = 1'b0;
        end else if (status_rq && !rst) begin
            if (hold_cnt == 0) begin
                status_start = 1'b1;
                hold_cnt = $urandom_range(0, max_delay);
            end else begin
                hold_cnt = hold_cnt - 1;
            end
        end
    end

    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] cmd;
        cmd = {data, addr};                              // AL first
        for (int i = 0; i < cmd_num_bytes; i++) begin
            @(negedge mclk);
            cmd_stb_in = (i == 0);
            cmd_ad_in  = cmd[8*i +: 8];
        end
        @(negedge mclk);
        cmd_ad_in = 8'h00;
        @(negedge mclk);                                 // 7 cycles after the strobe
        wr_go     = 1'b1;
        wr_addr_m = addr;
        wr_data_m = data;
        @(negedge mclk);
        wr_go = 1'b0;
    endtask

    task automatic frame(input logic [3:0] mask, input int n);
        @(negedge mclk) sof_in = mask;
        @(negedge mclk) sof_in = '0;
        repeat (n) begin
            @(negedge mclk) line_in = mask;
            @(negedge mclk) line_in = '0;
        end
        @(negedge mclk) eof_in = mask;
        @(negedge mclk) eof_in = '0;
        repeat (2) @(negedge mclk);
    endtask

    task automatic wait_packets(input int n);
        while (pkt_cnt < n) @(negedge mclk);
        repeat (6) @(negedge mclk);                      // let the last bytes pass
    endtask

    initial begin
        #(watchdog_ns);
        stop_on_failure("watchdog expired before the tests finished");
    end

    initial begin
        seed_rd = $urandom(32'h42dbbb9f);
        rst = 1'b1;
        cmd_ad_in = 8'h00;
        cmd_stb_in = 1'b0;
        sof_in = '0;
        eof_in = '0;
        line_in = '0;
        status_start = 1'b0;
        wr_go = 1'b0;
        wr_addr_m = '0;
        wr_data_m = '0;
        max_delay = 0;
        hold_cnt = 0;
        repeat (8) @(negedge mclk);
        rst = 1'b0;
        repeat (4) @(negedge mclk);                      // idle outputs stay low
        frame(4'hf, 18);                                 // default late of 15 lines
        c = $urandom_range(0, 3);
        l = $urandom_range(1, 10);
        write_reg(chn_addr(c, sens_sync_late), 32'(l));
        write_reg(chn_addr((c + 1) % 4, sens_sync_late), 32'(l + 3));
        write_reg(16'h0300 + 16'(sens_sync_late), 32'd2); // outside the group
        frame(4'hf, 14);
        m = $urandom_range(1, 3);
        write_reg(chn_addr(c, sens_sync_mult), 32'(m));
        repeat (2 * (m + 1)) frame(4'(1 << c), 6);
        write_reg(chn_addr(c, sens_sync_late), 32'd40);  // beyond the group length
        repeat (2 * (m + 1)) frame(4'(1 << c), 5);
        seq = 6'($urandom);
        write_reg(chn_addr(c, sens_status_ctrl), 32'({seq, 2'b01}));
        wait_packets(1);
        frame(4'(1 << c), 5);                            // group stays open, no late sof yet
        seq = 6'($urandom);
        write_reg(chn_addr(c, sens_status_ctrl), 32'({seq, 2'b01}));
        wait_packets(2);
        write_reg(chn_addr(c, sens_sync_mult), 32'd0);
        max_delay = 6;
        for (int k = 0; k < 4; k++) begin
            seq = 6'($urandom);
            write_reg(chn_addr(k, sens_sync_late), 32'd4);
            write_reg(chn_addr(k, sens_status_ctrl), 32'({seq, 2'b10}));
        end
        frame(4'hf, 8);
        wait_packets(6);
        repeat (20) @(negedge mclk);
        if (pkt_cnt == 6) begin
            $display("Simulation passed");
            $finish;
        end else begin
            report_mismatch("pkt_cnt", 32'(pkt_cnt), 32'd6);
        end
    end

endmodule

`default_nettype wire

// ==== logic/sensors_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sensors_top (
    input  wire                                mclk,
    input  wire                                rst,
    input  wire  [7:0]                         cmd_ad_in,     // AL, AH, D0..D3
    input  wire                                cmd_stb_in,    // with AL
    input  wire  [sens_pkg::sens_num_chn-1:0]  sof_in,
    input  wire  [sens_pkg::sens_num_chn-1:0]  eof_in,
    input  wire  [sens_pkg::sens_num_chn-1:0]  line_in,
    output logic [sens_pkg::sens_num_chn-1:0]  sof_out_mclk,  // group start, to sequencer
    output logic [sens_pkg::sens_num_chn-1:0]  eof_out_mclk,  // group end
    output logic [sens_pkg::sens_num_chn-1:0]  sof_late_mclk, // delayed sof
    output logic [7:0]                         status_ad,     // merged status bytes
    output logic                               status_rq,
    input  wire                                status_start
);

    import sens_pkg::*;

    logic [7:0]                   cmd_ad;                     // registered command bus
    logic                         cmd_stb;
    logic                         wr_stb;
    logic [cmd_addr_w-1:0]        wr_addr;
    logic [cmd_data_w-1:0]        wr_data;
    logic [sens_num_chn-1:0]      in_frame;
    logic [sens_num_chn-1:0]      rq_chn;
    logic [sens_num_chn-1:0]      start_chn;
    logic [sens_num_chn-1:0][7:0] db_chn;

    always_ff @(posedge mclk) begin
        if (rst) begin
            cmd_stb <= 1'b0;
        end else begin
            cmd_stb <= cmd_stb_in;
        end
    end

    always_ff @(posedge mclk) begin
        cmd_ad <= cmd_ad_in;
    end

    cmd_deframer cmd_deframer_i (
        .mclk    (mclk),
        .rst     (rst),
        .cmd_ad  (cmd_ad),
        .cmd_stb (cmd_stb),
        .wr_stb  (wr_stb),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    for (genvar i = 0; i < sens_num_chn; i++) begin : g_chn
        sens_sync #(.chn(i)) sens_sync_i (
            .mclk     (mclk),
            .rst      (rst),
            .wr_stb   (wr_stb),
            .wr_addr  (wr_addr),
            .wr_data  (wr_data),
            .sof_in   (sof_in[i]),
            .eof_in   (eof_in[i]),
            .line_in  (line_in[i]),
            .sof_out  (sof_out_mclk[i]),
            .eof_out  (eof_out_mclk[i]),
            .sof_late (sof_late_mclk[i]),
            .in_frame (in_frame[i])
        );

        chan_status #(.chn(i)) chan_status_i (
            .mclk     (mclk),
            .rst      (rst),
            .wr_stb   (wr_stb),
            .wr_addr  (wr_addr),
            .wr_data  (wr_data),
            .sof_out  (sof_out_mclk[i]),
            .sof_late (sof_late_mclk[i]),
            .in_frame (in_frame[i]),
            .rq       (rq_chn[i]),
            .start    (start_chn[i]),
            .db       (db_chn[i])
        );
    end

    status_router4 status_router4_i (
        .mclk         (mclk),
        .rst          (rst),
        .rq_in        (rq_chn),
        .db_in        (db_chn),
        .start_in     (start_chn),
        .status_rq    (status_rq),
        .status_ad    (status_ad),
        .status_start (status_start)
    );

endmodule

`default_nettype wire

// ==== logic/status_router4.sv ====
`timescale 1ns/1ps
`default_nettype none

module status_router4 (
    input  wire                                      mclk,
    input  wire                                      rst,
    input  wire  [sens_pkg::sens_num_chn-1:0]        rq_in,        // per-channel request
    input  wire  [sens_pkg::sens_num_chn-1:0][7:0]   db_in,        // per-channel byte
    output logic [sens_pkg::sens_num_chn-1:0]        start_in,     // start to chosen channel
    output logic                                     status_rq,
    output logic [7:0]                               status_ad,
    input  wire                                      status_start  // downstream took byte 0
);

    import sens_pkg::*;

    localparam int chn_w = $clog2(sens_num_chn);
    localparam int cnt_w = $clog2(status_pkt_bytes);

    router_state_e    state;
    logic [chn_w-1:0] sel;                             // channel being served
    logic [chn_w-1:0] nxt_sel;
    logic             any_rq;
    logic [cnt_w-1:0] byte_cnt;                        // byte on status_ad in send

    // round robin, nearest channel after sel wins
    always_comb begin
        logic [chn_w-1:0] cand;
        nxt_sel = sel;
        any_rq  = 1'b0;
        for (int k = sens_num_chn; k >= 1; k--) begin
            cand = chn_w'((sel + k) % sens_num_chn);
            if (rq_in[cand]) begin
                nxt_sel = cand;
                any_rq  = 1'b1;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (rst) begin
            state    <= rt_idle;
            sel      <= chn_w'(sens_num_chn - 1);      // channel 0 first
            byte_cnt <= '0;
        end else begin
            case (state)
                rt_idle: begin
                    if (any_rq) begin
                        sel   <= nxt_sel;
                        state <= rt_offer;
                    end
                end
                rt_offer: begin
                    if (status_start) begin            // may wait any number of cycles
                        byte_cnt <= cnt_w'(1);
                        state    <= rt_send;
                    end
                end
                rt_send: begin
                    if (byte_cnt == cnt_w'(status_pkt_bytes - 1)) begin
                        state <= rt_idle;              // rearbitrate next cycle
                    end
                    byte_cnt <= byte_cnt + 1'b1;
                end
                default: state <= rt_idle;
            endcase
        end
    end

    assign status_rq = (state == rt_offer) && rq_in[sel];
    assign status_ad = db_in[sel];                     // channel steps its own bytes

    always_comb begin
        start_in = '0;
        if (state == rt_offer) begin
            start_in[sel] = status_start;
        end
    end

endmodule

`default_nettype wire

// ==== logic/chan_status.sv ====
`timescale 1ns/1ps
`default_nettype none

module chan_status #(
    parameter int chn = 0
) (
    input  wire                              mclk,
    input  wire                              rst,
    input  wire                              wr_stb,
    input  wire  [sens_pkg::cmd_addr_w-1:0]  wr_addr,
    input  wire  [sens_pkg::cmd_data_w-1:0]  wr_data,
    input  wire                              sof_out,
    input  wire                              sof_late,
    input  wire                              in_frame,
    output logic                             rq,       // held until start
    input  wire                              start,    // byte 0 taken
    output logic [7:0]                       db        // packet byte
);

    import sens_pkg::*;

    localparam int idx_w = $clog2(status_pkt_bytes);
    localparam logic [cmd_addr_w-1:0] ctrl_addr =
        cmd_addr_w'(sensor_group_addr + chn * sensor_base_inc + sens_status_ctrl);
    localparam logic [7:0] st_addr = 8'(status_reg_base + chn * status_reg_inc);

    status_mode_e            mode;
    logic [status_seq_w-1:0] seq;
    logic [frame_cnt_w-1:0]  frame_cnt;                // counts sof_out
    logic                    late_done;                // late sof seen this group
    logic [idx_w-1:0]        byte_idx;                 // 0 idle or requesting
    logic [7:0]              snap_flags;               // seq, late_done, in_frame
    logic [frame_cnt_w-1:0]  snap_frame;
    logic                    mode_wr;
    logic                    event_rq;
    logic [status_seq_w-1:0] seq_nx;
    logic [frame_cnt_w-1:0]  frame_nx;
    logic                    late_nx;

    assign mode_wr  = wr_stb && (wr_addr == ctrl_addr);
    assign seq_nx   = mode_wr ? wr_data[2 +: status_seq_w] : seq;
    assign frame_nx = frame_cnt + frame_cnt_w'(sof_out);
    assign late_nx  = sof_late || (late_done && !sof_out);
    assign event_rq = ((mode_wr && wr_data[1:0] == st_once) || (sof_late && mode == st_auto))
                      && !rq && (byte_idx == '0);      // busy drops the event

    always_ff @(posedge mclk) begin
        if (rst) begin
            mode      <= st_off;
            seq       <= '0;
            frame_cnt <= '0;
            late_done <= 1'b0;
            rq        <= 1'b0;
            byte_idx  <= '0;
        end else begin
            frame_cnt <= frame_nx;
            late_done <= late_nx;
            if (mode_wr) begin
                seq  <= seq_nx;
                mode <= (wr_data[1:0] == st_auto) ? st_auto : st_off;  // once is one-shot
            end
            if (event_rq) begin
                rq <= 1'b1;
            end else if (start) begin
                rq <= 1'b0;
            end
            if (start && rq) begin
                byte_idx <= idx_w'(1);
            end else if (byte_idx != '0) begin
                byte_idx <= byte_idx + 1'b1;           // wraps back to 0 after last
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (event_rq) begin
            snap_flags <= {seq_nx, late_nx, in_frame};
            snap_frame <= frame_nx;
        end
    end

    always_comb begin
        case (byte_idx)
            idx_w'(1): db = snap_flags;
            idx_w'(2): db = snap_frame[7:0];
            idx_w'(3): db = snap_frame[15:8];
            default:   db = st_addr;                   // address while requesting
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/sens_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module sens_sync #(
    parameter int chn = 0                                 // channel index
) (
    input  wire                              mclk,
    input  wire                              rst,
    input  wire                              wr_stb,
    input  wire  [sens_pkg::cmd_addr_w-1:0]  wr_addr,
    input  wire  [sens_pkg::cmd_data_w-1:0]  wr_data,
    input  wire                              sof_in,      // sensor start of frame
    input  wire                              eof_in,      // sensor end of frame
    input  wire                              line_in,     // one pulse per line
    output logic                             sof_out,     // first frame of a group
    output logic                             eof_out,     // last frame of a group
    output logic                             sof_late,    // sof delayed by late lines
    output logic                             in_frame     // group in progress
);

    import sens_pkg::*;

    localparam int chn_base = sensor_group_addr + chn * sensor_base_inc;
    localparam logic [cmd_addr_w-1:0] mult_addr = cmd_addr_w'(chn_base + sens_sync_mult);
    localparam logic [cmd_addr_w-1:0] late_addr = cmd_addr_w'(chn_base + sens_sync_late);

    logic [sens_sync_fbits-1:0] mult;                     // frames combined minus one
    logic [sens_sync_lbits-1:0] late;                     // lines before sof_late
    logic [sens_sync_fbits-1:0] skip_cnt;                 // frames still to skip
    logic [sens_sync_lbits-1:0] line_cnt;                 // lines since accepted sof
    logic                       late_done;                // sof_late already issued
    logic                       accept;
    logic                       closing;
    logic                       line_hit;
    logic                       count_line;

    assign accept     = sof_in && (skip_cnt == '0);
    assign closing    = eof_in && in_frame && (skip_cnt == '0);  // last frame of group
    assign count_line = line_in && in_frame && !late_done;
    assign line_hit   = count_line && (line_cnt + 1'b1 == late);

    always_ff @(posedge mclk) begin
        if (rst) begin
            mult      <= '0;
            late      <= sens_sync_lbits'(sens_sync_late_dflt);
            skip_cnt  <= '0;
            line_cnt  <= '0;
            late_done <= 1'b1;                            // nothing pending
            in_frame  <= 1'b0;
            sof_out   <= 1'b0;
            eof_out   <= 1'b0;
            sof_late  <= 1'b0;
        end else begin
            sof_out  <= accept;
            eof_out  <= closing;
            sof_late <= (accept && late == '0) || line_hit || (closing && !late_done);

            if (wr_stb && wr_addr == mult_addr) begin
                mult     <= wr_data[sens_sync_fbits-1:0];
                skip_cnt <= '0;                           // next sof starts a group
            end else if (sof_in) begin
                skip_cnt <= accept ? mult : skip_cnt - 1'b1;
            end

            if (wr_stb && wr_addr == late_addr) begin
                late <= wr_data[sens_sync_lbits-1:0];
            end

            if (accept) begin
                in_frame  <= 1'b1;
                line_cnt  <= '0;
                late_done <= (late == '0);                // zero delay fires with sof
            end else begin
                if (count_line) begin
                    line_cnt <= line_cnt + 1'b1;
                end
                if (line_hit) begin
                    late_done <= 1'b1;
                end
                if (closing) begin
                    in_frame  <= 1'b0;
                    late_done <= 1'b1;                    // eof cuts the delay short
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/cmd_deframer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_deframer (
    input  wire                              mclk,
    input  wire                              rst,
    input  wire  [7:0]                       cmd_ad,   // byte-serial address/data
    input  wire                              cmd_stb,  // marks AL
    output logic                             wr_stb,   // one pulse per full command
    output logic [sens_pkg::cmd_addr_w-1:0]  wr_addr,
    output logic [sens_pkg::cmd_data_w-1:0]  wr_data
);

    import sens_pkg::*;

    cmd_phase_e phase;                                 // byte taken last cycle
    logic       data_byte;                             // current byte goes to data

    assign data_byte = !cmd_stb && (phase inside {ph_ah, ph_d0, ph_d1, ph_d2});

    always_ff @(posedge mclk) begin
        if (rst) begin
            phase  <= ph_idle;
            wr_stb <= 1'b0;
        end else begin
            wr_stb <= 1'b0;
            if (cmd_stb) begin
                phase <= ph_al;                        // any strobe restarts
            end else begin
                case (phase)
                    ph_al: phase <= ph_ah;
                    ph_ah: phase <= ph_d0;
                    ph_d0: phase <= ph_d1;
                    ph_d1: phase <= ph_d2;
                    ph_d2: begin
                        phase  <= ph_d3;               // D3 in this cycle
                        wr_stb <= 1'b1;
                    end
                    default: phase <= ph_idle;         // idle, or write just issued
                endcase
            end
        end
    end

    // low byte first, shift down
    always_ff @(posedge mclk) begin
        if (cmd_stb || phase == ph_al) begin
            wr_addr <= {cmd_ad, wr_addr[cmd_addr_w-1:8]};
        end
        if (data_byte) begin
            wr_data <= {cmd_ad, wr_data[cmd_data_w-1:8]};
        end
    end

endmodule

`default_nettype wire

// ==== logic/sens_pkg.sv ====
`default_nettype none

package sens_pkg;

    localparam int sens_num_chn = 4;            // sensor channels

    // command bus
    localparam int cmd_addr_w    = 16;
    localparam int cmd_data_w    = 32;
    localparam int cmd_num_bytes = 6;           // AL, AH, D0, D1, D2, D3

    // register map, byte addresses on the command bus
    localparam int sensor_group_addr = 'h400;   // channel 0 base
    localparam int sensor_base_inc   = 'h40;    // step between channels
    localparam int sens_status_ctrl  = 5;       // status mode and sequence
    localparam int sens_sync_mult    = 6;       // frames per group minus one
    localparam int sens_sync_late    = 7;       // late sof delay in lines

    localparam int sens_sync_late_dflt = 15;

    // status packets
    localparam int status_reg_base  = 'h20;     // status address of channel 0
    localparam int status_reg_inc   = 2;
    localparam int status_seq_w     = 6;
    localparam int status_pkt_bytes = 4;        // address, flags, count lo, count hi

    // counter widths
    localparam int sens_sync_fbits = 16;
    localparam int sens_sync_lbits = 16;
    localparam int frame_cnt_w     = 16;

    typedef enum logic [1:0] {
        st_off  = 2'd0,
        st_once = 2'd1,                         // one packet, then back to off
        st_auto = 2'd2                          // packet on every late sof
    } status_mode_e;                            // 3 behaves as off

    typedef enum logic [$clog2(cmd_num_bytes + 1)-1:0] {
        ph_idle, ph_al, ph_ah, ph_d0, ph_d1, ph_d2, ph_d3
    } cmd_phase_e;                              // last byte taken

    typedef enum logic [1:0] {
        rt_idle,                                // pick next channel
        rt_offer,                               // request shown, wait for start
        rt_send                                 // pass remaining bytes
    } router_state_e;

endpackage

`default_nettype wire
